// File: design/ieu_pkg.sv
// shared widths, opcodes and bus structs for the integer execution unit.
// the opcode enum is 4 bits wide; codes above opc_modu are never dispatched.
package ieu_pkg;

   // data word width of the core.
   localparam int data_w = 32;

   // result tag width, which bounds the number of operations in flight.
   localparam int tag_w = 4;

   // move-high places operand 2's low 17 bits starting at this bit.
   localparam int mhi_shift = 15;

   // step count of the iterative multiplier and divider, one bit per step.
   localparam int iter_n = 32;

   // width of the step counters inside the iterative units.
   localparam int iter_w = $clog2(iter_n);

   // operation codes.
   // the first four go to the arithmetic unit, the next six to the logic unit.
   typedef enum logic [3:0] {
      opc_add  = 4'd0,
      opc_sub  = 4'd1,
      opc_cmp  = 4'd2,
      opc_mhi  = 4'd3,
      opc_and  = 4'd4,
      opc_or   = 4'd5,
      opc_xor  = 4'd6,
      opc_sll  = 4'd7,
      opc_srl  = 4'd8,
      opc_sra  = 4'd9,
      opc_mul  = 4'd10,
      opc_divu = 4'd11,
      opc_modu = 4'd12
   } ieu_opc_e;

   // one issued operation.
   // cmp_eq and cmp_signed only matter for opc_cmp.
   typedef struct packed {
      ieu_opc_e              opc;
      logic [data_w-1:0]     operand_1;
      logic [data_w-1:0]     operand_2;
      logic                  cmp_eq;
      logic                  cmp_signed;
      logic [tag_w-1:0]      tag;
   } ieu_issue_t;

   // result offered by one unit to the writeback arbiter.
   typedef struct packed {
      logic                  valid;
      logic [tag_w-1:0]      tag;
      logic [data_w-1:0]     value;
   } ieu_res_t;

   // payload of the shared writeback bus.
   typedef struct packed {
      logic [tag_w-1:0]      tag;
      logic [data_w-1:0]     value;
   } ieu_wb_t;

endpackage

// File: design/ieu_au.sv
// combinational arithmetic unit for add, sub, compare and move-high.
// au_res is only meaningful for add, sub and mhi; cmp drives the flag outputs only.
`timescale 1ns/1ns

module ieu_au import ieu_pkg::*; (
   input  ieu_issue_t         op,
   output logic [data_w-1:0]  au_res,
   output logic               au_cc_we,
   output logic               au_cc_nxt
);

   logic [data_w-1:0] adder_operand_2;
   logic [data_w-1:0] adder_sum;
   logic              adder_sub;
   logic              adder_carry_out;
   logic              adder_overflow;
   logic [data_w-1:0] mhi_value;
   logic              cmp_equal;
   logic              cmp_gt_s;
   logic              cmp_gt_u;

   // compare shares the subtractor, so it takes the same complement path as sub.
   assign adder_sub = (op.opc == opc_sub) || (op.opc == opc_cmp);

   // subtraction is operand_1 + ~operand_2 + 1.
   // the carry-in is simply the subtract select.
   assign adder_operand_2 = adder_sub ? ~op.operand_2 : op.operand_2;

   assign {adder_carry_out, adder_sum} = {1'b0, op.operand_1}
                                       + {1'b0, adder_operand_2}
                                       + {{data_w{1'b0}}, adder_sub};

   // two's complement overflow happens when both adder inputs share a sign.
   // the sum then carries the other sign.
   assign adder_overflow = (op.operand_1[data_w-1] == adder_operand_2[data_w-1])
                         & (op.operand_1[data_w-1] ^ adder_sum[data_w-1]);

   // equality is taken straight from the operands.
   assign cmp_equal = (op.operand_1 == op.operand_2);

   // signed greater means the difference is non-negative once corrected for overflow.
   // equal operands are removed.
   assign cmp_gt_s = (adder_sum[data_w-1] == adder_overflow) & ~cmp_equal;

   // unsigned greater means no borrow out of the subtraction and unequal operands.
   assign cmp_gt_u = adder_carry_out & ~cmp_equal;

   // the flag is written only for compare.
   // cmp_eq overrides cmp_signed when both are set.
   assign au_cc_we = (op.opc == opc_cmp);

   always_comb begin
      if (op.cmp_eq) begin
         au_cc_nxt = cmp_equal;
      end else if (op.cmp_signed) begin
         au_cc_nxt = cmp_gt_s;
      end else begin
         au_cc_nxt = cmp_gt_u;
      end
   end

   // move-high loads operand 2's low 17 bits into the upper part of the word.
   assign mhi_value = {op.operand_2[data_w-mhi_shift-1:0], {mhi_shift{1'b0}}};

   // result select.
   // cmp also returns the difference here, but the top never writes it back.
   assign au_res = (op.opc == opc_mhi) ? mhi_value : adder_sum;

endmodule

// File: design/ieu_lu.sv
// combinational logic and barrel-shift unit.
// the shift amount is operand 2's low 5 bits; the upper bits are ignored.
`timescale 1ns/1ns

module ieu_lu import ieu_pkg::*; (
   input  ieu_issue_t         op,
   output logic [data_w-1:0]  lu_res
);

   logic [$clog2(data_w)-1:0] shamt;
   logic [data_w-1:0]         sra_value;

   // only the low bits of operand 2 select the shift distance.
   assign shamt = op.operand_2[$clog2(data_w)-1:0];

   // arithmetic right shift fills with operand 1's sign bit.
   assign sra_value = $signed(op.operand_1) >>> shamt;

   always_comb begin
      unique case (op.opc)
         opc_and: begin
            lu_res = op.operand_1 & op.operand_2;
         end
         opc_or: begin
            lu_res = op.operand_1 | op.operand_2;
         end
         opc_xor: begin
            lu_res = op.operand_1 ^ op.operand_2;
         end
         opc_sll: begin
            lu_res = op.operand_1 << shamt;
         end
         opc_srl: begin
            lu_res = op.operand_1 >> shamt;
         end
         opc_sra: begin
            lu_res = sra_value;
         end
         default: begin
            // codes outside this unit's set give zero.
            // the top never writes them back from here.
            lu_res = '0;
         end
      endcase
   end

endmodule

// File: design/ieu_mul.sv
// iterative shift-add multiplier returning the low product word after 32 steps.
// start must not arrive while busy; flush wins over a start in the same cycle.
`timescale 1ns/1ns

module ieu_mul import ieu_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        start,
   input  ieu_issue_t  op,
   input  logic        grant,
   output ieu_res_t    res,
   output logic        busy
);

   logic                running;
   logic                done;
   logic [iter_w-1:0]   step_cnt;
   logic [data_w-1:0]   mcand;
   logic [data_w-1:0]   mplier;
   logic [data_w-1:0]   acc;
   logic [tag_w-1:0]    tag_q;

   // control state.
   // done holds the finished result until the arbiter grants the bus.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running  <= 1'b0;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (flush) begin
         running  <= 1'b0;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (start) begin
         running  <= 1'b1;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (running) begin
         step_cnt <= step_cnt + 1'b1;
         // the last step lands on the edge 32 cycles after start.
         if (step_cnt == iter_w'(iter_n - 1)) begin
            running <= 1'b0;
            done    <= 1'b1;
         end
      end else if (done && grant) begin
         done <= 1'b0;
      end
   end

   // datapath.
   // each step adds the shifted multiplicand when the multiplier's low bit is set.
   // bits shifted out above the word are dropped, leaving the low product word.
   always_ff @(posedge clk) begin
      if (start) begin
         mcand  <= op.operand_1;
         mplier <= op.operand_2;
         acc    <= '0;
         tag_q  <= op.tag;
      end else if (running) begin
         if (mplier[0]) begin
            acc <= acc + mcand;
         end
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign res.valid = done;
   assign res.tag   = tag_q;
   assign res.value = acc;

   // busy covers the whole span from start until the result is granted.
   assign busy = running | done;

endmodule

// File: design/ieu_div.sv
// iterative restoring unsigned divider returning quotient or remainder.
// divide by zero gives an all-ones quotient and a remainder equal to the dividend.
`timescale 1ns/1ns

module ieu_div import ieu_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        start,
   input  ieu_issue_t  op,
   input  logic        grant,
   output ieu_res_t    res,
   output logic        busy
);

   logic                running;
   logic                done;
   logic [iter_w-1:0]   step_cnt;
   logic [data_w-1:0]   quot;
   logic [data_w-1:0]   rem;
   logic [data_w-1:0]   divisor;
   logic                want_mod;
   logic [tag_w-1:0]    tag_q;
   logic [data_w:0]     rem_shift;
   logic [data_w:0]     rem_trial;
   logic                fits;

   // one restoring step.
   // the next dividend bit comes out of the top of the quotient register.
   // that register fills from the bottom with quotient bits as it empties.
   assign rem_shift = {rem, quot[data_w-1]};
   assign fits      = (rem_shift >= {1'b0, divisor});
   assign rem_trial = rem_shift - {1'b0, divisor};

   // control state follows the same sequencing as the multiplier.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running  <= 1'b0;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (flush) begin
         running  <= 1'b0;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (start) begin
         running  <= 1'b1;
         done     <= 1'b0;
         step_cnt <= '0;
      end else if (running) begin
         step_cnt <= step_cnt + 1'b1;
         if (step_cnt == iter_w'(iter_n - 1)) begin
            running <= 1'b0;
            done    <= 1'b1;
         end
      end else if (done && grant) begin
         done <= 1'b0;
      end
   end

   // datapath.
   // with a zero divisor every trial fits, so each quotient bit is one.
   // the remainder then collects the dividend bit by bit.
   always_ff @(posedge clk) begin
      if (start) begin
         quot     <= op.operand_1;
         rem      <= '0;
         divisor  <= op.operand_2;
         want_mod <= (op.opc == opc_modu);
         tag_q    <= op.tag;
      end else if (running) begin
         quot <= {quot[data_w-2:0], fits};
         // the upper bit of the trial is always zero when it fits and the divisor is nonzero.
         rem  <= fits ? rem_trial[data_w-1:0] : rem_shift[data_w-1:0];
      end
   end

   assign res.valid = done;
   assign res.tag   = tag_q;
   assign res.value = want_mod ? rem : quot;

   assign busy = running | done;

endmodule

// File: design/ieu_wb_arb.sv
// fixed-priority writeback arbiter with the condition flag register.
// the single-cycle result always wins, so only the iterative units ever wait.
`timescale 1ns/1ns

module ieu_wb_arb import ieu_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        sc_valid,
   input  ieu_wb_t     sc_res,
   input  logic        cc_we,
   input  logic        cc_nxt,
   input  ieu_res_t    div_res,
   input  ieu_res_t    mul_res,
   output logic        div_grant,
   output logic        mul_grant,
   output logic        wb_valid,
   output ieu_wb_t     wb,
   output logic        cc
);

   ieu_wb_t wb_nxt;
   logic    any_valid;

   // priority is single-cycle, then div, then mul.
   // a grant is a one-cycle pulse that the unit sees on the same edge the bus registers.
   assign div_grant = ~sc_valid & div_res.valid;
   assign mul_grant = ~sc_valid & ~div_res.valid & mul_res.valid;

   assign any_valid = sc_valid | div_res.valid | mul_res.valid;

   always_comb begin
      if (sc_valid) begin
         wb_nxt = sc_res;
      end else if (div_res.valid) begin
         wb_nxt.tag   = div_res.tag;
         wb_nxt.value = div_res.value;
      end else begin
         // mul is the lowest priority and also the idle default.
         wb_nxt.tag   = mul_res.tag;
         wb_nxt.value = mul_res.value;
      end
   end

   // writeback strobe and condition flag.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid <= 1'b0;
         cc       <= 1'b0;
      end else begin
         wb_valid <= any_valid;
         if (cc_we) begin
            cc <= cc_nxt;
         end
      end
   end

   // the payload register loads whenever some unit offers a result.
   always_ff @(posedge clk) begin
      if (any_valid) begin
         wb <= wb_nxt;
      end
   end

endmodule

// File: design/ieu_top.sv
// integer execution unit top level with dispatch to four units and one writeback bus.
// the issuer must not start mul or div while the matching busy level is high.
`timescale 1ns/1ns

module ieu_top import ieu_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        op_valid,
   input  logic        flush,
   input  ieu_issue_t  op,
   output logic        wb_valid,
   output ieu_wb_t     wb,
   output logic        cc,
   output logic        mul_busy,
   output logic        div_busy
);

   logic [data_w-1:0] au_res;
   logic [data_w-1:0] lu_res;
   logic              au_cc_we;
   logic              au_cc_nxt;
   logic              is_au_wb;
   logic              is_lu;
   logic              mul_start;
   logic              div_start;
   logic              sc_valid;
   ieu_wb_t           sc_res;
   ieu_res_t          mul_res;
   ieu_res_t          div_res;
   logic              mul_grant;
   logic              div_grant;

   // class decode.
   // cmp belongs to the arithmetic unit but produces no writeback.
   assign is_au_wb  = (op.opc == opc_add) || (op.opc == opc_sub) || (op.opc == opc_mhi);
   assign is_lu     = (op.opc >= opc_and) && (op.opc <= opc_sra);
   assign mul_start = op_valid && (op.opc == opc_mul);
   assign div_start = op_valid && ((op.opc == opc_divu) || (op.opc == opc_modu));

   assign sc_valid     = op_valid && (is_au_wb || is_lu);
   assign sc_res.tag   = op.tag;
   assign sc_res.value = is_au_wb ? au_res : lu_res;

   ieu_au u_au (
      .op        (op),
      .au_res    (au_res),
      .au_cc_we  (au_cc_we),
      .au_cc_nxt (au_cc_nxt)
   );

   ieu_lu u_lu (
      .op     (op),
      .lu_res (lu_res)
   );

   ieu_mul u_mul (
      .clk    (clk),
      .arst_n (arst_n),
      .flush  (flush),
      .start  (mul_start),
      .op     (op),
      .grant  (mul_grant),
      .res    (mul_res),
      .busy   (mul_busy)
   );

   ieu_div u_div (
      .clk    (clk),
      .arst_n (arst_n),
      .flush  (flush),
      .start  (div_start),
      .op     (op),
      .grant  (div_grant),
      .res    (div_res),
      .busy   (div_busy)
   );

   // the flag write is qualified by the issue strobe here.
   ieu_wb_arb u_wb_arb (
      .clk       (clk),
      .arst_n    (arst_n),
      .sc_valid  (sc_valid),
      .sc_res    (sc_res),
      .cc_we     (op_valid & au_cc_we),
      .cc_nxt    (au_cc_nxt),
      .div_res   (div_res),
      .mul_res   (mul_res),
      .div_grant (div_grant),
      .mul_grant (mul_grant),
      .wb_valid  (wb_valid),
      .wb        (wb),
      .cc        (cc)
   );

endmodule

// File: testbench/ieu_checker.sv
// scoreboard for the execution unit; keeps one expected value per tag in flight.
// samples on the rising edge, so it sees the values that held just before the edge.
`timescale 1ns/1ns

module ieu_checker import ieu_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       op_valid,
   input  logic       flush,
   input  ieu_issue_t op,
   input  logic       wb_valid,
   input  ieu_wb_t    wb,
   input  logic       cc,
   input  logic       mul_busy,
   input  logic       div_busy,
   output int         value_errs,
   output int         other_errs,
   output int         pending_cnt
);

   logic [data_w-1:0] exp_val [2**tag_w];
   logic              pending [2**tag_w];
   logic              mul_live;
   logic              div_live;
   logic [tag_w-1:0]  mul_tag;
   logic [tag_w-1:0]  div_tag;
   logic              sc_due;
   logic [tag_w-1:0]  sc_tag;
   logic              cc_due;
   logic              cc_exp;
   logic              flush_seen;
   logic              first;

   // expected writeback value of one operation.
   function automatic logic [data_w-1:0] expect_value(input ieu_issue_t o);
      logic [4:0]        sh;
      logic [data_w-1:0] fill;
      sh   = o.operand_2[4:0];
      fill = o.operand_1[data_w-1] ? ~(32'hffff_ffff >> sh) : 32'h0;
      case (o.opc)
         opc_add:  return o.operand_1 + o.operand_2;
         opc_sub:  return o.operand_1 - o.operand_2;
         opc_mhi:  return o.operand_2 << mhi_shift;
         opc_and:  return o.operand_1 & o.operand_2;
         opc_or:   return o.operand_1 | o.operand_2;
         opc_xor:  return o.operand_1 ^ o.operand_2;
         opc_sll:  return o.operand_1 << sh;
         opc_srl:  return o.operand_1 >> sh;
         opc_sra:  return (o.operand_1 >> sh) | fill;
         opc_mul:  return o.operand_1 * o.operand_2;
         opc_divu: return (o.operand_2 == 0) ? 32'hffff_ffff : o.operand_1 / o.operand_2;
         opc_modu: return (o.operand_2 == 0) ? o.operand_1 : o.operand_1 % o.operand_2;
         default:  return 32'h0;
      endcase
   endfunction

   // equal wins over signed, as in the compare encoding.
   function automatic logic predict_cc(input ieu_issue_t o);
      if (o.cmp_eq) begin
         return o.operand_1 == o.operand_2;
      end else if (o.cmp_signed) begin
         return $signed(o.operand_1) > $signed(o.operand_2);
      end
      return o.operand_1 > o.operand_2;
   endfunction

   always @(posedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**tag_w; i++) begin
            pending[i] = 1'b0;
         end
         {mul_live, div_live, sc_due, cc_due, flush_seen} = '0;
         first       = 1'b1;
         value_errs  = 0;
         other_errs  = 0;
         pending_cnt = 0;
      end else begin
         // outputs must come out of reset idle.
         if (first && (wb_valid || mul_busy || div_busy || cc)) begin
            $display("outputs were not idle right after reset");
            other_errs++;
         end
         first = 1'b0;
         if (flush_seen && (mul_busy || div_busy)) begin
            $display("a busy level was still high one cycle after flush");
            other_errs++;
         end
         // busy may only fall together with its own writeback.
         if (mul_live && !mul_busy && !(wb_valid && wb.tag == mul_tag)) begin
            $display("mul_busy fell before tag %h was written back", mul_tag);
            other_errs++;
         end
         if (div_live && !div_busy && !(wb_valid && wb.tag == div_tag)) begin
            $display("div_busy fell before tag %h was written back", div_tag);
            other_errs++;
         end
         if (sc_due && !(wb_valid && wb.tag == sc_tag)) begin
            $display("single-cycle tag %h was not written back one cycle after issue", sc_tag);
            other_errs++;
         end
         if (cc_due && cc !== cc_exp) begin
            $display("[FAIL] cc: expected %h, got %h", cc_exp, cc);
            value_errs++;
         end
         if (wb_valid) begin
            if (!pending[wb.tag]) begin
               $display("writeback of tag %h, which is not in flight", wb.tag);
               other_errs++;
            end else begin
               if (wb.value !== exp_val[wb.tag]) begin
                  $display("[FAIL] wb.value tag %h: expected %h, got %h",
                           wb.tag, exp_val[wb.tag], wb.value);
                  value_errs++;
               end
               pending[wb.tag] = 1'b0;
               pending_cnt--;
               if (mul_live && wb.tag == mul_tag) begin
                  mul_live = 1'b0;
               end
               if (div_live && wb.tag == div_tag) begin
                  div_live = 1'b0;
               end
            end
         end
         sc_due = 1'b0;
         cc_due = 1'b0;
         // a flush drops whatever the iterative units still hold.
         if (flush && mul_live) begin
            pending[mul_tag] = 1'b0;
            pending_cnt--;
            mul_live = 1'b0;
         end
         if (flush && div_live) begin
            pending[div_tag] = 1'b0;
            pending_cnt--;
            div_live = 1'b0;
         end
         if (op_valid && op.opc == opc_cmp) begin
            cc_due = 1'b1;
            cc_exp = predict_cc(op);
         end else if (op_valid) begin
            if (pending[op.tag]) begin
               $display("tag %h was issued while still in flight", op.tag);
               other_errs++;
            end else begin
               pending_cnt++;
            end
            pending[op.tag] = 1'b1;
            exp_val[op.tag] = expect_value(op);
            if (op.opc == opc_mul) begin
               mul_live = 1'b1;
               mul_tag  = op.tag;
            end else if (op.opc == opc_divu || op.opc == opc_modu) begin
               div_live = 1'b1;
               div_tag  = op.tag;
            end else begin
               sc_due = 1'b1;
               sc_tag = op.tag;
            end
         end
         flush_seen = flush;
      end
   end

endmodule

// File: testbench/tb_ieu.sv
// testbench for the integer execution unit. it applies a stimulus table on falling edges.
// tags 14 and 15 are kept for mul and div, so they never meet a single-cycle tag.
`timescale 1ns/1ns

module tb_ieu import ieu_pkg::*; ();

   // one table row; a flush row ignores the operation fields.
   typedef struct packed {
      ieu_opc_e          opc;
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      logic              cmp_eq;
      logic              cmp_signed;
      logic              do_flush;
      logic [7:0]        idle;
   } stim_t;

   logic       clk;
   logic       arst_n;
   logic       op_valid;
   logic       flush;
   ieu_issue_t op;
   logic       wb_valid;
   ieu_wb_t    wb;
   logic       cc;
   logic       mul_busy;
   logic       div_busy;
   int         value_errs;
   int         other_errs;
   int         pending_cnt;
   stim_t      stim_q[$];
   int         table_len = 0;
   integer     seed;

   always #5 clk = ~clk;

   ieu_top u_ieu_top (
      .clk      (clk),
      .arst_n   (arst_n),
      .op_valid (op_valid),
      .flush    (flush),
      .op       (op),
      .wb_valid (wb_valid),
      .wb       (wb),
      .cc       (cc),
      .mul_busy (mul_busy),
      .div_busy (div_busy)
   );

   ieu_checker u_checker (
      .clk         (clk),
      .arst_n      (arst_n),
      .op_valid    (op_valid),
      .flush       (flush),
      .op          (op),
      .wb_valid    (wb_valid),
      .wb          (wb),
      .cc          (cc),
      .mul_busy    (mul_busy),
      .div_busy    (div_busy),
      .value_errs  (value_errs),
      .other_errs  (other_errs),
      .pending_cnt (pending_cnt)
   );

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic add_op(input ieu_opc_e opc, input logic [31:0] a, input logic [31:0] b,
                         input logic cmp_eq, input logic cmp_signed, input int idle);
      stim_t e;
      e.opc        = opc;
      e.a          = a;
      e.b          = b;
      e.cmp_eq     = cmp_eq;
      e.cmp_signed = cmp_signed;
      e.do_flush   = 1'b0;
      e.idle       = 8'(idle);
      stim_q.push_back(e);
   endtask

   task automatic queue_flush(input int idle);
      stim_t e;
      e          = '0;
      e.do_flush = 1'b1;
      e.idle     = 8'(idle);
      stim_q.push_back(e);
   endtask

   task automatic build_table();
      // add and sub corners cover a plain sum, a carry-out wrap and signed overflow both ways.
      add_op(opc_add, 32'h0000_0001, 32'h0000_0002, 1'b0, 1'b0, 0);
      add_op(opc_add, 32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0, 0);
      add_op(opc_add, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 1'b0, 0);
      add_op(opc_sub, 32'h0000_0000, 32'h0000_0001, 1'b0, 1'b0, 0);
      add_op(opc_sub, 32'h8000_0000, 32'h0000_0001, 1'b0, 1'b0, 1);
      // compares on operands that differ only in the sign bit.
      add_op(opc_cmp, 32'h0000_0005, 32'h0000_0005, 1'b1, 1'b0, 0);
      add_op(opc_cmp, 32'h0000_0001, 32'h8000_0001, 1'b1, 1'b0, 0);
      add_op(opc_cmp, 32'h0000_0001, 32'h8000_0001, 1'b0, 1'b1, 0);
      add_op(opc_cmp, 32'h0000_0001, 32'h8000_0001, 1'b0, 1'b0, 0);
      add_op(opc_cmp, 32'h8000_0001, 32'h0000_0001, 1'b0, 1'b1, 0);
      add_op(opc_cmp, 32'h8000_0001, 32'h0000_0001, 1'b0, 1'b0, 1);
      // move-high, logic ops and shifts with amounts 0 and 31 and a negative sra.
      add_op(opc_mhi, 32'h1234_5678, 32'h0001_ffff, 1'b0, 1'b0, 0);
      add_op(opc_mhi, 32'h0000_0000, 32'hfffe_0001, 1'b0, 1'b0, 0);
      add_op(opc_and, 32'hf0f0_ff00, 32'h0ff0_f0f0, 1'b0, 1'b0, 0);
      add_op(opc_or,  32'hf0f0_ff00, 32'h0ff0_f0f0, 1'b0, 1'b0, 0);
      add_op(opc_xor, 32'hf0f0_ff00, 32'h0ff0_f0f0, 1'b0, 1'b0, 0);
      add_op(opc_sll, 32'h0000_0001, 32'h0000_001f, 1'b0, 1'b0, 0);
      add_op(opc_sll, 32'hdead_beef, 32'h0000_0000, 1'b0, 1'b0, 0);
      add_op(opc_srl, 32'h8000_0000, 32'h0000_001f, 1'b0, 1'b0, 0);
      add_op(opc_srl, 32'hdead_beef, 32'hffff_ffe0, 1'b0, 1'b0, 0);
      add_op(opc_sra, 32'h8000_0000, 32'h0000_0004, 1'b0, 1'b0, 0);
      add_op(opc_sra, 32'h8000_0001, 32'h0000_001f, 1'b0, 1'b0, 0);
      add_op(opc_sra, 32'h7fff_0000, 32'h0000_0008, 1'b0, 1'b0, 2);
      // iterative ops with both divide-by-zero results.
      add_op(opc_mul,  32'h1234_5678, 32'h9abc_def0, 1'b0, 1'b0, 0);
      add_op(opc_mul,  32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, 0);
      add_op(opc_divu, 32'h0000_0064, 32'h0000_0007, 1'b0, 1'b0, 0);
      add_op(opc_modu, 32'h0000_0064, 32'h0000_0007, 1'b0, 1'b0, 0);
      add_op(opc_divu, 32'hcafe_f00d, 32'h0000_0000, 1'b0, 1'b0, 0);
      add_op(opc_modu, 32'hcafe_f00d, 32'h0000_0000, 1'b0, 1'b0, 40);
      // mul and div run together while single-cycle ops issue every cycle.
      add_op(opc_mul,  32'hdead_beef, 32'h0123_4567, 1'b0, 1'b0, 0);
      add_op(opc_divu, 32'hfedc_ba98, 32'h0000_0013, 1'b0, 1'b0, 0);
      for (int i = 0; i < 36; i++) begin
         add_op(ieu_opc_e'(4'(rand_below(10))), $random(seed), $random(seed),
                1'(rand_below(2)), 1'(rand_below(2)), 0);
      end
      // a flush a few cycles into both iterative ops drops their tags.
      add_op(opc_mul,  32'h0000_0003, 32'h0000_0005, 1'b0, 1'b0, 0);
      add_op(opc_modu, 32'h0000_0011, 32'h0000_0005, 1'b0, 1'b0, 6);
      queue_flush(2);
      for (int i = 0; i < 40; i++) begin
         add_op(ieu_opc_e'(4'(rand_below(13))), $random(seed), $random(seed),
                1'(rand_below(2)), 1'(rand_below(2)), rand_below(2));
      end
   endtask

   initial begin
      stim_t e;
      int    sc_tag;
      clk      = 1'b0;
      arst_n   = 1'b0;
      op_valid = 1'b0;
      flush    = 1'b0;
      op       = '0;
      seed     = 32'h4922463b;
      sc_tag   = 0;
      build_table();
      table_len = stim_q.size();
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < table_len; i++) begin
         e = stim_q[i];
         // the issuer never starts an iterative unit that is still busy.
         if (!e.do_flush && e.opc == opc_mul) begin
            while (mul_busy) @(negedge clk);
         end
         if (!e.do_flush && (e.opc == opc_divu || e.opc == opc_modu)) begin
            while (div_busy) @(negedge clk);
         end
         op.opc        = e.opc;
         op.operand_1  = e.a;
         op.operand_2  = e.b;
         op.cmp_eq     = e.cmp_eq;
         op.cmp_signed = e.cmp_signed;
         if (e.opc == opc_mul) begin
            op.tag = 4'd14;
         end else if (e.opc == opc_divu || e.opc == opc_modu) begin
            op.tag = 4'd15;
         end else begin
            op.tag = 4'(sc_tag);
            sc_tag = (sc_tag == 13) ? 0 : sc_tag + 1;
         end
         op_valid = ~e.do_flush;
         flush    = e.do_flush;
         @(negedge clk);
         op_valid = 1'b0;
         flush    = 1'b0;
         repeat (int'(e.idle)) @(negedge clk);
      end
      // drain the iterative units before the final tally.
      while (mul_busy || div_busy) @(negedge clk);
      repeat (3) @(negedge clk);
      if (pending_cnt != 0) begin
         $display("%0d tags were issued but never written back", pending_cnt);
      end
      $display("errors: %0d value, %0d protocol, %0d tags left pending",
               value_errs, other_errs, pending_cnt);
      if (value_errs + other_errs + pending_cnt == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // the watchdog limit grows with the table so a stuck unit cannot hang the run.
   initial begin
      wait (table_len > 0);
      repeat (table_len * 40 + 200) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", table_len * 40 + 200);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: src.f
design/ieu_pkg.sv
design/ieu_au.sv
design/ieu_lu.sv
design/ieu_mul.sv
design/ieu_div.sv
design/ieu_wb_arb.sv
design/ieu_top.sv
testbench/ieu_checker.sv
testbench/tb_ieu.sv

// File: Makefile
# Verilator flow for the integer execution unit.
# sim passes only when the log holds the pass line.

TOP = tb_ieu
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module ieu_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
